// ==== hw/exe_pkg.sv ====
package exe_pkg;

    // datapath and register file sizes
    localparam int XLEN = 32;
    localparam int PREG_NUM = 32;
    localparam int ROB_SIZE = 16;

    // issue and writeback widths
    localparam int IQ_DEPTH = 4;
    localparam int WB_PORTS = 2;
    localparam int MARK_PORTS = 2;

    // two sources for each of the two dispatch paths
    localparam int CHK_PORTS = 4;
    localparam int RD_PORTS = 4;

    typedef logic [$clog2(PREG_NUM)-1:0] preg_idx_t;
    typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;

    // queue slot index and occupancy count
    typedef logic [$clog2(IQ_DEPTH)-1:0] iq_idx_t;
    typedef logic [$clog2(IQ_DEPTH+1)-1:0] iq_cnt_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // imm_vld selects imm in place of source 2
    typedef struct packed {
        alu_op_e           op;
        logic              imm_vld;
        logic [XLEN-1:0]   imm;
    } alu_payload_t;

    // mul_hi is the signed upper half
    typedef enum logic {
        MUL_LO = 1'b0,
        MUL_HI = 1'b1
    } mul_op_e;

    typedef struct packed {
        mul_op_e op;
    } mul_payload_t;

endpackage

// ==== hw/phys_regfile.sv ====
`timescale 1ns/100ps

module phys_regfile import exe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // rename marks, destination becomes not ready
    input  logic [MARK_PORTS-1:0] i_mark_vld,
    input  preg_idx_t             i_mark_preg [MARK_PORTS],

    // source readiness at dispatch
    input  preg_idx_t             i_chk_preg [CHK_PORTS],
    output logic [CHK_PORTS-1:0]  o_chk_rdy,

    // operand reads at issue
    input  preg_idx_t             i_rd_preg [RD_PORTS],
    output logic [XLEN-1:0]       o_rd_data [RD_PORTS],

    input  logic [WB_PORTS-1:0]   i_wb_vld,
    input  preg_idx_t             i_wb_preg [WB_PORTS],
    input  logic [XLEN-1:0]       i_wb_data [WB_PORTS]
);

    logic [XLEN-1:0]     preg_data [PREG_NUM];
    logic [PREG_NUM-1:0] preg_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PREG_NUM; r++) begin
                preg_data[r] <= '0;
            end
        end else begin
            for (int p = 0; p < WB_PORTS; p++) begin
                if (i_wb_vld[p] && i_wb_preg[p] != '0) begin
                    preg_data[i_wb_preg[p]] <= i_wb_data[p];
                end
            end
        end
    end

    // marks come after writebacks so a newer producer wins
    always_ff @(posedge clk) begin
        if (rst) begin
            preg_rdy <= '1;
        end else begin
            for (int p = 0; p < WB_PORTS; p++) begin
                if (i_wb_vld[p]) begin
                    preg_rdy[i_wb_preg[p]] <= 1'b1;
                end
            end
            for (int m = 0; m < MARK_PORTS; m++) begin
                if (i_mark_vld[m] && i_mark_preg[m] != '0) begin
                    preg_rdy[i_mark_preg[m]] <= 1'b0;
                end
            end
        end
    end

    // same-cycle writeback counts as ready
    always_comb begin
        for (int c = 0; c < CHK_PORTS; c++) begin
            o_chk_rdy[c] = preg_rdy[i_chk_preg[c]];
            for (int p = 0; p < WB_PORTS; p++) begin
                if (i_wb_vld[p] && i_wb_preg[p] == i_chk_preg[c]) begin
                    o_chk_rdy[c] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            o_rd_data[r] = (i_rd_preg[r] == '0) ? '0 : preg_data[i_rd_preg[r]];
        end
    end

endmodule

// ==== hw/issue_queue.sv ====
`timescale 1ns/100ps

module issue_queue import exe_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_squash,

    input  logic                i_disp_vld,
    output logic                o_disp_rdy,
    input  preg_idx_t           i_disp_prs1,
    input  preg_idx_t           i_disp_prs2,
    input  logic                i_disp_prs1_rdy,
    input  logic                i_disp_prs2_rdy,
    input  preg_idx_t           i_disp_prd,
    input  rob_idx_t            i_disp_rob,
    input  payload_t            i_disp_payload,

    // writeback broadcast
    input  logic [WB_PORTS-1:0] i_wk_vld,
    input  preg_idx_t           i_wk_preg [WB_PORTS],

    output logic                o_iss_vld,
    output preg_idx_t           o_iss_prs1,
    output preg_idx_t           o_iss_prs2,
    output preg_idx_t           o_iss_prd,
    output rob_idx_t            o_iss_rob,
    output payload_t            o_iss_payload
);

    // slot 0 is the oldest, valid slots are packed from the bottom
    logic [IQ_DEPTH-1:0] ent_vld;
    logic [IQ_DEPTH-1:0] ent_rdy1;
    logic [IQ_DEPTH-1:0] ent_rdy2;
    preg_idx_t           ent_prs1 [IQ_DEPTH];
    preg_idx_t           ent_prs2 [IQ_DEPTH];
    preg_idx_t           ent_prd [IQ_DEPTH];
    rob_idx_t            ent_rob [IQ_DEPTH];
    payload_t            ent_payload [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] rdy1_nx;
    logic [IQ_DEPTH-1:0] rdy2_nx;
    logic [IQ_DEPTH-1:0] shift;
    iq_idx_t             sel_idx;
    iq_cnt_t             ent_cnt;
    iq_cnt_t             enq_pos;
    logic                disp_fire;

    assign o_disp_rdy = ~ent_vld[IQ_DEPTH-1];
    assign disp_fire = i_disp_vld & o_disp_rdy;

    // wakeup from either writeback port
    always_comb begin
        rdy1_nx = ent_rdy1;
        rdy2_nx = ent_rdy2;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            for (int p = 0; p < WB_PORTS; p++) begin
                if (i_wk_vld[p] && i_wk_preg[p] == ent_prs1[i]) begin
                    rdy1_nx[i] = 1'b1;
                end
                if (i_wk_vld[p] && i_wk_preg[p] == ent_prs2[i]) begin
                    rdy2_nx[i] = 1'b1;
                end
            end
        end
    end

    // oldest ready wins, hence the downward scan
    always_comb begin
        sel_idx = '0;
        o_iss_vld = 1'b0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (ent_vld[i] && ent_rdy1[i] && ent_rdy2[i]) begin
                sel_idx = iq_idx_t'(i);
                o_iss_vld = 1'b1;
            end
        end
    end

    always_comb begin
        ent_cnt = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ent_cnt = ent_cnt + iq_cnt_t'(ent_vld[i]);
            shift[i] = o_iss_vld && (i >= sel_idx);
        end
    end

    assign enq_pos = ent_cnt - iq_cnt_t'(o_iss_vld);

    assign o_iss_prs1 = ent_prs1[sel_idx];
    assign o_iss_prs2 = ent_prs2[sel_idx];
    assign o_iss_prd = ent_prd[sel_idx];
    assign o_iss_rob = ent_rob[sel_idx];
    assign o_iss_payload = ent_payload[sel_idx];

    always_ff @(posedge clk) begin
        if (rst || i_squash) begin
            ent_vld <= '0;
            ent_rdy1 <= '0;
            ent_rdy2 <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH - 1; i++) begin
                if (shift[i]) begin
                    ent_vld[i] <= ent_vld[i+1];
                    ent_rdy1[i] <= rdy1_nx[i+1];
                    ent_rdy2[i] <= rdy2_nx[i+1];
                end else begin
                    ent_rdy1[i] <= rdy1_nx[i];
                    ent_rdy2[i] <= rdy2_nx[i];
                end
            end
            if (shift[IQ_DEPTH-1]) begin
                ent_vld[IQ_DEPTH-1] <= 1'b0;
            end else begin
                ent_rdy1[IQ_DEPTH-1] <= rdy1_nx[IQ_DEPTH-1];
                ent_rdy2[IQ_DEPTH-1] <= rdy2_nx[IQ_DEPTH-1];
            end
            // new entry lands above the survivors
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (disp_fire && enq_pos == i) begin
                    ent_vld[i] <= 1'b1;
                    ent_rdy1[i] <= i_disp_prs1_rdy;
                    ent_rdy2[i] <= i_disp_prs2_rdy;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH - 1; i++) begin
            if (shift[i]) begin
                ent_prs1[i] <= ent_prs1[i+1];
                ent_prs2[i] <= ent_prs2[i+1];
                ent_prd[i] <= ent_prd[i+1];
                ent_rob[i] <= ent_rob[i+1];
                ent_payload[i] <= ent_payload[i+1];
            end
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (disp_fire && enq_pos == i) begin
                ent_prs1[i] <= i_disp_prs1;
                ent_prs2[i] <= i_disp_prs2;
                ent_prd[i] <= i_disp_prd;
                ent_rob[i] <= i_disp_rob;
                ent_payload[i] <= i_disp_payload;
            end
        end
    end

endmodule

// ==== hw/int_alu.sv ====
`timescale 1ns/100ps

module int_alu import exe_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_squash,

    input  logic            i_vld,
    input  alu_payload_t    i_payload,
    input  logic [XLEN-1:0] i_src1,
    input  logic [XLEN-1:0] i_src2,
    input  preg_idx_t       i_prd,
    input  rob_idx_t        i_rob,

    output logic            o_wb_vld,
    output preg_idx_t       o_wb_preg,
    output rob_idx_t        o_wb_rob,
    output logic [XLEN-1:0] o_wb_data
);

    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] result;

    assign opb = i_payload.imm_vld ? i_payload.imm : i_src2;

    always_comb begin
        case (i_payload.op)
            ALU_ADD: result = i_src1 + opb;
            ALU_SUB: result = i_src1 - opb;
            ALU_AND: result = i_src1 & opb;
            ALU_OR:  result = i_src1 | opb;
            ALU_XOR: result = i_src1 ^ opb;
            // shift amount from low 5 bits only
            ALU_SLL: result = i_src1 << opb[4:0];
            ALU_SRL: result = i_src1 >> opb[4:0];
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(i_src1) < $signed(opb)};
            default: result = '0;
        endcase
    end

    // squash kills whatever issued this cycle
    always_ff @(posedge clk) begin
        if (rst || i_squash) begin
            o_wb_vld <= 1'b0;
        end else begin
            o_wb_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_preg <= i_prd;
        o_wb_rob <= i_rob;
        o_wb_data <= result;
    end

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit import exe_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_squash,

    input  logic            i_vld,
    input  mul_payload_t    i_payload,
    input  logic [XLEN-1:0] i_src1,
    input  logic [XLEN-1:0] i_src2,
    input  preg_idx_t       i_prd,
    input  rob_idx_t        i_rob,

    output logic            o_wb_vld,
    output preg_idx_t       o_wb_preg,
    output rob_idx_t        o_wb_rob,
    output logic [XLEN-1:0] o_wb_data
);

    // stage 1 operands
    logic                   s1_vld;
    mul_op_e                s1_op;
    logic [XLEN-1:0]        s1_a;
    logic [XLEN-1:0]        s1_b;
    preg_idx_t              s1_prd;
    rob_idx_t               s1_rob;

    // stage 2 full product
    logic                   s2_vld;
    mul_op_e                s2_op;
    logic signed [2*XLEN-1:0] s2_prod;
    preg_idx_t              s2_prd;
    rob_idx_t               s2_rob;

    always_ff @(posedge clk) begin
        if (rst || i_squash) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            o_wb_vld <= 1'b0;
        end else begin
            s1_vld <= i_vld;
            s2_vld <= s1_vld;
            o_wb_vld <= s2_vld;
        end
    end

    always_ff @(posedge clk) begin
        s1_op <= i_payload.op;
        s1_a <= i_src1;
        s1_b <= i_src2;
        s1_prd <= i_prd;
        s1_rob <= i_rob;

        s2_op <= s1_op;
        s2_prod <= $signed(s1_a) * $signed(s1_b);
        s2_prd <= s1_prd;
        s2_rob <= s1_rob;

        // half select
        o_wb_data <= (s2_op == MUL_HI) ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
        o_wb_preg <= s2_prd;
        o_wb_rob <= s2_rob;
    end

endmodule

// ==== hw/exe_block.sv ====
`timescale 1ns/100ps

module exe_block import exe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_squash,

    input  logic [MARK_PORTS-1:0] i_mark_vld,
    input  preg_idx_t             i_mark_preg [MARK_PORTS],

    input  logic                  i_alu_disp_vld,
    output logic                  o_alu_disp_rdy,
    input  preg_idx_t             i_alu_disp_prs1,
    input  preg_idx_t             i_alu_disp_prs2,
    input  preg_idx_t             i_alu_disp_prd,
    input  rob_idx_t              i_alu_disp_rob,
    input  alu_payload_t          i_alu_disp_payload,

    input  logic                  i_mul_disp_vld,
    output logic                  o_mul_disp_rdy,
    input  preg_idx_t             i_mul_disp_prs1,
    input  preg_idx_t             i_mul_disp_prs2,
    input  preg_idx_t             i_mul_disp_prd,
    input  rob_idx_t              i_mul_disp_rob,
    input  mul_payload_t          i_mul_disp_payload,

    // port 0 alu, port 1 multiplier
    output logic [WB_PORTS-1:0]   o_wb_vld,
    output preg_idx_t             o_wb_preg [WB_PORTS],
    output rob_idx_t              o_wb_rob [WB_PORTS],
    output logic [XLEN-1:0]       o_wb_data [WB_PORTS]
);

    preg_idx_t             chk_preg [CHK_PORTS];
    logic [CHK_PORTS-1:0]  chk_rdy;
    preg_idx_t             rd_preg [RD_PORTS];
    logic [XLEN-1:0]       rd_data [RD_PORTS];

    logic                  alu_iss_vld;
    preg_idx_t             alu_iss_prs1;
    preg_idx_t             alu_iss_prs2;
    preg_idx_t             alu_iss_prd;
    rob_idx_t              alu_iss_rob;
    alu_payload_t          alu_iss_payload;

    logic                  mul_iss_vld;
    preg_idx_t             mul_iss_prs1;
    preg_idx_t             mul_iss_prs2;
    preg_idx_t             mul_iss_prd;
    rob_idx_t              mul_iss_rob;
    mul_payload_t          mul_iss_payload;

    // check ports 0,1 alu sources, 2,3 mul sources
    assign chk_preg[0] = i_alu_disp_prs1;
    assign chk_preg[1] = i_alu_disp_prs2;
    assign chk_preg[2] = i_mul_disp_prs1;
    assign chk_preg[3] = i_mul_disp_prs2;

    // read ports follow the same order
    assign rd_preg[0] = alu_iss_prs1;
    assign rd_preg[1] = alu_iss_prs2;
    assign rd_preg[2] = mul_iss_prs1;
    assign rd_preg[3] = mul_iss_prs2;

    phys_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .i_mark_vld (i_mark_vld),
        .i_mark_preg(i_mark_preg),
        .i_chk_preg (chk_preg),
        .o_chk_rdy  (chk_rdy),
        .i_rd_preg  (rd_preg),
        .o_rd_data  (rd_data),
        .i_wb_vld   (o_wb_vld),
        .i_wb_preg  (o_wb_preg),
        .i_wb_data  (o_wb_data)
    );

    issue_queue #(.payload_t(alu_payload_t)) u_alu_iq (
        .clk            (clk),
        .rst            (rst),
        .i_squash       (i_squash),
        .i_disp_vld     (i_alu_disp_vld),
        .o_disp_rdy     (o_alu_disp_rdy),
        .i_disp_prs1    (i_alu_disp_prs1),
        .i_disp_prs2    (i_alu_disp_prs2),
        .i_disp_prs1_rdy(chk_rdy[0]),
        .i_disp_prs2_rdy(chk_rdy[1]),
        .i_disp_prd     (i_alu_disp_prd),
        .i_disp_rob     (i_alu_disp_rob),
        .i_disp_payload (i_alu_disp_payload),
        .i_wk_vld       (o_wb_vld),
        .i_wk_preg      (o_wb_preg),
        .o_iss_vld      (alu_iss_vld),
        .o_iss_prs1     (alu_iss_prs1),
        .o_iss_prs2     (alu_iss_prs2),
        .o_iss_prd      (alu_iss_prd),
        .o_iss_rob      (alu_iss_rob),
        .o_iss_payload  (alu_iss_payload)
    );

    issue_queue #(.payload_t(mul_payload_t)) u_mul_iq (
        .clk            (clk),
        .rst            (rst),
        .i_squash       (i_squash),
        .i_disp_vld     (i_mul_disp_vld),
        .o_disp_rdy     (o_mul_disp_rdy),
        .i_disp_prs1    (i_mul_disp_prs1),
        .i_disp_prs2    (i_mul_disp_prs2),
        .i_disp_prs1_rdy(chk_rdy[2]),
        .i_disp_prs2_rdy(chk_rdy[3]),
        .i_disp_prd     (i_mul_disp_prd),
        .i_disp_rob     (i_mul_disp_rob),
        .i_disp_payload (i_mul_disp_payload),
        .i_wk_vld       (o_wb_vld),
        .i_wk_preg      (o_wb_preg),
        .o_iss_vld      (mul_iss_vld),
        .o_iss_prs1     (mul_iss_prs1),
        .o_iss_prs2     (mul_iss_prs2),
        .o_iss_prd      (mul_iss_prd),
        .o_iss_rob      (mul_iss_rob),
        .o_iss_payload  (mul_iss_payload)
    );

    int_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .i_squash (i_squash),
        .i_vld    (alu_iss_vld),
        .i_payload(alu_iss_payload),
        .i_src1   (rd_data[0]),
        .i_src2   (rd_data[1]),
        .i_prd    (alu_iss_prd),
        .i_rob    (alu_iss_rob),
        .o_wb_vld (o_wb_vld[0]),
        .o_wb_preg(o_wb_preg[0]),
        .o_wb_rob (o_wb_rob[0]),
        .o_wb_data(o_wb_data[0])
    );

    mul_unit u_mul (
        .clk      (clk),
        .rst      (rst),
        .i_squash (i_squash),
        .i_vld    (mul_iss_vld),
        .i_payload(mul_iss_payload),
        .i_src1   (rd_data[2]),
        .i_src2   (rd_data[3]),
        .i_prd    (mul_iss_prd),
        .i_rob    (mul_iss_rob),
        .o_wb_vld (o_wb_vld[1]),
        .o_wb_preg(o_wb_preg[1]),
        .o_wb_rob (o_wb_rob[1]),
        .o_wb_data(o_wb_data[1])
    );

endmodule

// ==== tb/exe_block_assert.sv ====
`timescale 1ns/100ps

module exe_block_assert import exe_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                i_squash,
    input logic                i_alu_disp_rdy,
    input logic                i_mul_disp_rdy,
    input logic [WB_PORTS-1:0] i_wb_vld,
    input logic                i_alu_iss_vld,
    input logic                i_mul_iss_vld
);

    int err_cnt = 0;

    // state seen one cycle after any reset cycle
    reset_state: assert property (@(posedge clk)
        rst |=> (i_wb_vld == '0) && i_alu_disp_rdy && i_mul_disp_rdy)
        else begin $error("wrong state after reset"); err_cnt++; end

    alu_latency: assert property (@(posedge clk) disable iff (rst)
        i_wb_vld[0] == $past(i_alu_iss_vld && !i_squash))
        else begin $error("ALU writeback not one cycle after issue"); err_cnt++; end

    mul_latency: assert property (@(posedge clk) disable iff (rst)
        (i_mul_iss_vld && !i_squash) ##1 !i_squash ##1 !i_squash |=> i_wb_vld[1])
        else begin $error("multiply writeback missing three cycles after issue"); err_cnt++; end

    mul_no_stray: assert property (@(posedge clk) disable iff (rst)
        i_wb_vld[1] |-> $past(i_mul_iss_vld, 3))
        else begin $error("multiply writeback without an issue three cycles before"); err_cnt++; end

    // full queue with nothing issuing stays full and quiet
    alu_backpressure: assert property (@(posedge clk) disable iff (rst)
        !i_alu_disp_rdy && !i_alu_iss_vld && !i_squash |=> !i_alu_disp_rdy && !i_wb_vld[0])
        else begin $error("full ALU queue released or wrote back without issue"); err_cnt++; end

    // covers the whole multiplier pipeline
    squash_quiet: assert property (@(posedge clk) disable iff (rst)
        i_squash |=> (i_wb_vld == '0) [*3])
        else begin $error("writeback after squash"); err_cnt++; end

    squash_empty: assert property (@(posedge clk) disable iff (rst)
        i_squash |=> i_alu_disp_rdy && i_mul_disp_rdy)
        else begin $error("queues not empty after squash"); err_cnt++; end

endmodule

bind exe_block exe_block_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .i_squash      (i_squash),
    .i_alu_disp_rdy(o_alu_disp_rdy),
    .i_mul_disp_rdy(o_mul_disp_rdy),
    .i_wb_vld      (o_wb_vld),
    .i_alu_iss_vld (alu_iss_vld),
    .i_mul_iss_vld (mul_iss_vld)
);

// ==== tb/exe_block_tb.sv ====
`timescale 1ns/100ps

module exe_block_tb import exe_pkg::*; ();

    localparam int DRV = 10;
    localparam int TIMEOUT = 200;

    logic                  clk;
    logic                  rst;
    logic                  squash;
    logic [MARK_PORTS-1:0] mark_vld;
    preg_idx_t             mark_preg [MARK_PORTS];

    logic                  alu_vld;
    logic                  alu_rdy;
    preg_idx_t             alu_prs1;
    preg_idx_t             alu_prs2;
    preg_idx_t             alu_prd;
    rob_idx_t              alu_rob;
    alu_payload_t          alu_pl;

    logic                  mul_vld;
    logic                  mul_rdy;
    preg_idx_t             mul_prs1;
    preg_idx_t             mul_prs2;
    preg_idx_t             mul_prd;
    rob_idx_t              mul_rob;
    mul_payload_t          mul_pl;

    logic [WB_PORTS-1:0]   wb_vld;
    preg_idx_t             wb_preg [WB_PORTS];
    rob_idx_t              wb_rob [WB_PORTS];
    logic [XLEN-1:0]       wb_data [WB_PORTS];

    // reference state: values as seen once all dispatched ops complete
    logic [XLEN-1:0]       model [PREG_NUM];
    logic [PREG_NUM-1:0]   busy;
    logic [ROB_SIZE-1:0]   pend;
    preg_idx_t             exp_prd [ROB_SIZE];
    preg_idx_t             exp_src1 [ROB_SIZE];
    preg_idx_t             exp_src2 [ROB_SIZE];
    logic [XLEN-1:0]       exp_val [ROB_SIZE];
    rob_idx_t              rob_ctr;

    exe_block dut0 (
        .clk               (clk),
        .rst               (rst),
        .i_squash          (squash),
        .i_mark_vld        (mark_vld),
        .i_mark_preg       (mark_preg),
        .i_alu_disp_vld    (alu_vld),
        .o_alu_disp_rdy    (alu_rdy),
        .i_alu_disp_prs1   (alu_prs1),
        .i_alu_disp_prs2   (alu_prs2),
        .i_alu_disp_prd    (alu_prd),
        .i_alu_disp_rob    (alu_rob),
        .i_alu_disp_payload(alu_pl),
        .i_mul_disp_vld    (mul_vld),
        .o_mul_disp_rdy    (mul_rdy),
        .i_mul_disp_prs1   (mul_prs1),
        .i_mul_disp_prs2   (mul_prs2),
        .i_mul_disp_prd    (mul_prd),
        .i_mul_disp_rob    (mul_rob),
        .i_mul_disp_payload(mul_pl),
        .o_wb_vld          (wb_vld),
        .o_wb_preg         (wb_preg),
        .o_wb_rob          (wb_rob),
        .o_wb_data         (wb_data)
    );

    always #50 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_fail(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
        $display("test failed");
        $fatal(1, "simulation stopped on value mismatch");
    endtask

    function automatic logic [XLEN-1:0] alu_ref(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] mul_ref(input mul_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        logic signed [2*XLEN-1:0] prod;
        sa = $signed(a);
        sb = $signed(b);
        prod = sa * sb;
        return (op == MUL_HI) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    endfunction

    task automatic claim_rob(output rob_idx_t rob);
        int waited;
        waited = 0;
        while (pend[rob_ctr]) begin
            @(posedge clk);
            #DRV;
            waited++;
            if (waited > TIMEOUT) report_error("no ROB index became free");
        end
        rob = rob_ctr;
        rob_ctr = rob_ctr + 1'b1;
    endtask

    task automatic record(input rob_idx_t rob, input preg_idx_t rd, input preg_idx_t rs1,
                          input preg_idx_t rs2, input logic [XLEN-1:0] val);
        exp_prd[rob] = rd;
        exp_src1[rob] = rs1;
        exp_src2[rob] = rs2;
        exp_val[rob] = val;
        pend[rob] = 1'b1;
        model[rd] = val;
        busy[rd] = 1'b1;
    endtask

    task automatic send_alu(input alu_op_e op, input preg_idx_t rs1, input preg_idx_t rs2,
                            input logic imm_vld, input logic [XLEN-1:0] imm,
                            input preg_idx_t rd);
        rob_idx_t rob;
        int waited;
        claim_rob(rob);
        record(rob, rd, rs1, imm_vld ? preg_idx_t'(0) : rs2,
               alu_ref(op, model[rs1], imm_vld ? imm : model[rs2]));
        alu_pl = '{op: op, imm_vld: imm_vld, imm: imm};
        alu_prs1 = rs1;
        alu_prs2 = rs2;
        alu_prd = rd;
        alu_rob = rob;
        alu_vld = 1'b1;
        // rename marks the destination in the dispatch cycle
        mark_vld[0] = 1'b1;
        mark_preg[0] = rd;
        waited = 0;
        while (!alu_rdy) begin
            @(posedge clk);
            #DRV;
            waited++;
            if (waited > TIMEOUT) report_error("ALU dispatch was never accepted");
        end
        @(posedge clk);
        #DRV;
        alu_vld = 1'b0;
        mark_vld[0] = 1'b0;
    endtask

    task automatic send_mul(input mul_op_e op, input preg_idx_t rs1, input preg_idx_t rs2,
                            input preg_idx_t rd);
        rob_idx_t rob;
        int waited;
        claim_rob(rob);
        record(rob, rd, rs1, rs2, mul_ref(op, model[rs1], model[rs2]));
        mul_pl.op = op;
        mul_prs1 = rs1;
        mul_prs2 = rs2;
        mul_prd = rd;
        mul_rob = rob;
        mul_vld = 1'b1;
        mark_vld[1] = 1'b1;
        mark_preg[1] = rd;
        waited = 0;
        while (!mul_rdy) begin
            @(posedge clk);
            #DRV;
            waited++;
            if (waited > TIMEOUT) report_error("multiply dispatch was never accepted");
        end
        @(posedge clk);
        #DRV;
        mul_vld = 1'b0;
        mark_vld[1] = 1'b0;
    endtask

    task automatic mark_reg(input preg_idx_t r);
        mark_vld[0] = 1'b1;
        mark_preg[0] = r;
        @(posedge clk);
        #DRV;
        mark_vld[0] = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (pend != '0) begin
            @(posedge clk);
            #DRV;
            waited++;
            if (waited > TIMEOUT) report_error("outstanding instructions never wrote back");
        end
    endtask

    task automatic check_wb(input int p);
        rob_idx_t rob;
        rob = wb_rob[p];
        if (!pend[rob]) report_error($sformatf("writeback on port %0d for idle ROB %0d", p, rob));
        if (wb_preg[p] !== exp_prd[rob]) begin
            value_fail($sformatf("o_wb_preg[%0d]", p), XLEN'(wb_preg[p]), XLEN'(exp_prd[rob]));
        end
        if (wb_data[p] !== exp_val[rob]) begin
            value_fail($sformatf("o_wb_data[%0d]", p), wb_data[p], exp_val[rob]);
        end
        if (busy[exp_src1[rob]] || busy[exp_src2[rob]]) begin
            report_error($sformatf("ROB %0d wrote back before its producer", rob));
        end
        pend[rob] = 1'b0;
        busy[exp_prd[rob]] = 1'b0;
    endtask

    // outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_vld[p]) check_wb(p);
            end
            if (dut0.u_assert.err_cnt != 0) report_error("a bound assertion failed");
        end
    end

    initial begin
        preg_idx_t a;
        preg_idx_t b;
        void'($urandom(32'h101e));
        clk = 1'b0;
        rst = 1'b1;
        squash = 1'b0;
        mark_vld = '0;
        mark_preg = '{default: '0};
        alu_vld = 1'b0;
        alu_prs1 = '0;
        alu_prs2 = '0;
        alu_prd = '0;
        alu_rob = '0;
        alu_pl = '0;
        mul_vld = 1'b0;
        mul_prs1 = '0;
        mul_prs2 = '0;
        mul_prd = '0;
        mul_rob = '0;
        mul_pl = '0;
        model = '{default: '0};
        busy = '0;
        pend = '0;
        rob_ctr = '0;
        repeat (3) @(posedge clk);
        #DRV;
        rst = 1'b0;

        // fill r1..r15 with random values
        for (int r = 1; r < 16; r++) begin
            send_alu(ALU_ADD, '0, '0, 1'b1, $urandom, preg_idx_t'(r));
        end
        wait_idle();

        // every ALU opcode, register and immediate forms
        for (int i = 0; i < 24; i++) begin
            send_alu(alu_op_e'(i % 8), preg_idx_t'(1 + $urandom % 15),
                     preg_idx_t'(1 + $urandom % 15), 1'(($urandom) % 2), $urandom,
                     preg_idx_t'(16 + i % 8));
        end
        wait_idle();

        // dependent chain across both units
        send_alu(ALU_ADD, 5'd1, 5'd2, 1'b0, '0, 5'd24);
        send_mul(MUL_LO, 5'd24, 5'd3, 5'd25);
        send_alu(ALU_SUB, 5'd25, 5'd24, 1'b0, '0, 5'd26);
        send_mul(MUL_HI, 5'd26, 5'd25, 5'd27);
        send_alu(ALU_XOR, 5'd27, 5'd0, 1'b1, $urandom, 5'd28);
        wait_idle();

        // back-to-back multiplies keep three in flight
        for (int i = 0; i < 8; i++) begin
            send_mul(mul_op_e'(i % 2), preg_idx_t'(1 + $urandom % 15),
                     preg_idx_t'(1 + $urandom % 15), preg_idx_t'(16 + i));
        end
        wait_idle();

        // r29 stays pending until the multiply dispatched after the full queue
        a = preg_idx_t'(1 + $urandom % 15);
        b = preg_idx_t'(1 + $urandom % 15);
        model[29] = mul_ref(MUL_LO, model[a], model[b]);
        busy[29] = 1'b1;
        mark_reg(5'd29);
        for (int i = 0; i < IQ_DEPTH; i++) begin
            send_alu(alu_op_e'(i), 5'd29, preg_idx_t'(1 + $urandom % 15), 1'b0, '0,
                     preg_idx_t'(16 + i));
        end
        repeat (5) begin
            @(posedge clk);
            #DRV;
        end
        send_mul(MUL_LO, a, b, 5'd29);
        wait_idle();

        // squash with a full ALU queue and multiplies in flight
        mark_reg(5'd30);
        for (int i = 0; i < IQ_DEPTH; i++) begin
            send_alu(alu_op_e'(i), 5'd30, preg_idx_t'(8 + i), 1'b0, '0,
                     preg_idx_t'(16 + i));
        end
        send_mul(MUL_HI, 5'd4, 5'd5, 5'd20);
        send_mul(MUL_LO, 5'd6, 5'd7, 5'd21);
        squash = 1'b1;
        @(posedge clk);
        #DRV;
        squash = 1'b0;
        pend = '0;
        busy = '0;
        repeat (4) begin
            @(posedge clk);
            #DRV;
        end

        if (dut0.u_assert.err_cnt != 0) begin
            $display("test failed");
            $fatal(1, "simulation stopped with errors");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== files.f ====
hw/exe_pkg.sv
hw/phys_regfile.sv
hw/issue_queue.sv
hw/int_alu.sv
hw/mul_unit.sv
hw/exe_block.sv
tb/exe_block_assert.sv
tb/exe_block_tb.sv
